// File: common/motorRegPkg.sv
package motorRegPkg;

    localparam int CMD_W      = 32;
    localparam int PWM_LEN_W  = 12;
    localparam int MIN_MASK_W = 12;
    localparam int PL_LEN_W   = 16;
    localparam int STEP_LEN_W = 16;

    typedef enum logic [1:0] {
        ADDR_PWM    = 2'd0,
        ADDR_MOTION = 2'd1
    } regAddrT;

    // PWM timing view of the command word
    typedef struct packed {
        logic [PWM_LEN_W-1:0]                        pwmLenWant;
        logic [MIN_MASK_W-1:0]                       pwmMinMask;
        logic [CMD_W-PWM_LEN_W-MIN_MASK_W-1:0]       reserved;
    } pwmWordT;

    // motion setup view of the same word
    typedef struct packed {
        logic [PL_LEN_W-1:0]   plLen;
        logic [STEP_LEN_W-1:0] stepLen;
    } motionWordT;

    typedef union packed {
        pwmWordT    pwm;
        motionWordT motion;
    } cmdWordT;

    localparam logic [PWM_LEN_W-1:0]  PWM_LEN_RST  = 12'd100;
    localparam logic [MIN_MASK_W-1:0] MIN_MASK_RST = 12'd16;
    localparam logic [PL_LEN_W-1:0]   PL_LEN_RST   = 16'd0;
    localparam logic [STEP_LEN_W-1:0] STEP_LEN_RST = 16'd1000;

endpackage

// File: common/motorPwmPkg.sv
package motorPwmPkg;

    localparam int PWM_CNT_W  = 12;
    // pulse and carry values share this width
    localparam int POS_W      = 16;
    localparam int STEP_CNT_W = 16;
    localparam int NUM_PHASES = 6;

    // commutation phase, counts 0 to NUM_PHASES-1
    typedef logic [2:0] phaseT;

    localparam int DEAD_CYCLES = 4;

    // six-step table, leg index 0 to 2 for each phase
    // hi side walks A A B B C C while lo side walks B C C A A B
    localparam logic [1:0] phaseHiLeg [NUM_PHASES] = '{
        2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd2
    };

    localparam logic [1:0] phaseLoLeg [NUM_PHASES] = '{
        2'd1, 2'd2, 2'd2, 2'd0, 2'd0, 2'd1
    };

endpackage

// File: common/motorCfgIf.sv
interface motorCfgIf;
    import motorRegPkg::*;

    // applied configuration, stable for a whole commutation step
    logic [PWM_LEN_W-1:0]  pwmLenWant;
    logic [MIN_MASK_W-1:0] pwmMinMask;
    logic [PL_LEN_W-1:0]   plLen;
    logic [STEP_LEN_W-1:0] stepLen;

    modport src (
        output pwmLenWant,
        output pwmMinMask,
        output plLen,
        output stepLen
    );

    modport pwm (
        input pwmLenWant,
        input pwmMinMask,
        input plLen
    );

    modport seq (
        input stepLen
    );

endinterface

// File: rtl/motorRegs.sv
module motorRegs (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 cmdValid,
    output logic                 cmdReady,
    input  motorRegPkg::regAddrT cmdAddr,
    input  motorRegPkg::cmdWordT cmdData,
    input  logic                 stepLast,
    motorCfgIf.src               cfg
);
    import motorRegPkg::*;

    logic                  cmdAccept;
    logic [PWM_LEN_W-1:0]  shPwmLen;
    logic [MIN_MASK_W-1:0] shMinMask;
    logic [PL_LEN_W-1:0]   shPlLen;
    logic [STEP_LEN_W-1:0] shStepLen;

    assign cmdAccept = cmdValid & cmdReady;

    // one idle cycle after every accepted write
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmdReady <= 1'b1;
        end else begin
            cmdReady <= !cmdAccept;
        end
    end

    // the address selects which view of the union is decoded
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shPwmLen  <= PWM_LEN_RST;
            shMinMask <= MIN_MASK_RST;
            shPlLen   <= PL_LEN_RST;
            shStepLen <= STEP_LEN_RST;
        end else if (cmdAccept) begin
            case (cmdAddr)
                ADDR_PWM: begin
                    shPwmLen  <= cmdData.pwm.pwmLenWant;
                    shMinMask <= cmdData.pwm.pwmMinMask;
                end
                ADDR_MOTION: begin
                    shPlLen   <= cmdData.motion.plLen;
                    shStepLen <= cmdData.motion.stepLen;
                end
                default: begin
                    // unmapped address, write is dropped
                end
            endcase
        end
    end

    // shadow set moves over only at a step boundary so the
    // PWM and sequencer never see a half-updated configuration
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg.pwmLenWant <= PWM_LEN_RST;
            cfg.pwmMinMask <= MIN_MASK_RST;
            cfg.plLen      <= PL_LEN_RST;
            cfg.stepLen    <= STEP_LEN_RST;
        end else if (stepLast) begin
            cfg.pwmLenWant <= shPwmLen;
            cfg.pwmMinMask <= shMinMask;
            cfg.plLen      <= shPlLen;
            cfg.stepLen    <= shStepLen;
        end
    end

endmodule

// File: rtl/stepSequencer.sv
module stepSequencer (
    input  logic               clk,
    input  logic               rstN,
    motorCfgIf.seq             cfg,
    output logic               stepLast,
    output motorPwmPkg::phaseT phase
);
    import motorPwmPkg::*;

    logic [STEP_CNT_W-1:0] stepCnt;
    logic [STEP_CNT_W-1:0] lastCnt;

    assign lastCnt  = cfg.stepLen - 1'b1;
    assign stepLast = (stepCnt == lastCnt);

    // cycle count inside the current step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stepCnt <= '0;
        end else if (stepLast) begin
            stepCnt <= '0;
        end else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

    // commutation phase moves on the last cycle of each step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
        end else if (stepLast) begin
            if (phase == phaseT'(NUM_PHASES - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

endmodule

// File: pwm/pwmGenerator.sv
module pwmGenerator (
    input  logic   clk,
    input  logic   rstN,
    motorCfgIf.pwm cfg,
    input  logic   stepLast,
    output logic   pwm
);
    import motorPwmPkg::*;

    logic [PWM_CNT_W-1:0] pwmCnt;
    logic                 periodReload;
    logic                 periodReloadQ;
    logic                 pulseLoad;
    logic [POS_W-1:0]     carry;
    logic [POS_W-1:0]     candidate;
    logic                 tooShort;
    logic [POS_W-1:0]     pulseCnt;

    // the period restarts at its natural end, at a step boundary,
    // and is held in reload while no pulse length is set
    assign periodReload = stepLast | (pwmCnt == PWM_CNT_W'(1)) | (cfg.plLen == '0);

    // reset to 1 so the first cycle out of reset loads the period
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pwmCnt <= PWM_CNT_W'(1);
        end else if (periodReload) begin
            pwmCnt <= cfg.pwmLenWant;
        end else begin
            pwmCnt <= pwmCnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            periodReloadQ <= 1'b0;
        end else begin
            periodReloadQ <= periodReload;
        end
    end

    // a new pulse is formed on the first counting cycle after a reload
    assign pulseLoad = periodReloadQ & ~periodReload;

    assign candidate = carry + cfg.plLen;
    assign tooShort  = (candidate < POS_W'(cfg.pwmMinMask));

    // short pulses are not driven to the switches, their length waits
    // here until enough has built up, and the step end drops it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            carry <= '0;
        end else if (stepLast) begin
            carry <= '0;
        end else if (pulseLoad) begin
            carry <= tooShort ? candidate : '0;
        end
    end

    // pulse countdown, a new load cuts off whatever is left
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pulseCnt <= '0;
        end else if (pulseLoad) begin
            pulseCnt <= tooShort ? '0 : candidate;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    assign pwm = (pulseCnt != '0);

endmodule

// File: rtl/gateDriver.sv
module gateDriver (
    input  logic               clk,
    input  logic               rstN,
    input  motorPwmPkg::phaseT phase,
    input  logic               pwm,
    output logic [2:0]         gateHi,
    output logic [2:0]         gateLo,
    output logic               pwmOut,
    output motorPwmPkg::phaseT phaseOut
);
    import motorPwmPkg::*;

    localparam int DEAD_W = $clog2(DEAD_CYCLES + 1);

    logic              phaseChange;
    logic [DEAD_W-1:0] deadCnt;
    logic              blank;
    logic [2:0]        hiSel;
    logic [2:0]        loSel;

    // phaseOut holds last cycle's phase, so a mismatch marks a commutation
    assign phaseChange = (phase != phaseOut);
    assign blank       = phaseChange | (deadCnt != '0);

    assign hiSel = 3'b001 << phaseHiLeg[phase];
    assign loSel = 3'b001 << phaseLoLeg[phase];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phaseOut <= '0;
            pwmOut   <= 1'b0;
            deadCnt  <= '0;
        end else begin
            phaseOut <= phase;
            pwmOut   <= pwm;
            if (phaseChange) begin
                deadCnt <= DEAD_W'(DEAD_CYCLES - 1);
            end else if (deadCnt != '0) begin
                deadCnt <= deadCnt - 1'b1;
            end
        end
    end

    // all six switches stay open while the bridge settles after a commutation
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gateHi <= '0;
            gateLo <= '0;
        end else if (blank) begin
            gateHi <= '0;
            gateLo <= '0;
        end else begin
            gateHi <= hiSel & {3{pwm}};
            gateLo <= loSel;
        end
    end

endmodule

// File: rtl/motorCtrlTop.sv
module motorCtrlTop (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         cmdValid,
    output logic                         cmdReady,
    input  motorRegPkg::regAddrT         cmdAddr,
    input  logic [motorRegPkg::CMD_W-1:0] cmdData,
    output logic                         pwmOut,
    output motorPwmPkg::phaseT           phaseOut,
    output logic [2:0]                   gateHi,
    output logic [2:0]                   gateLo
);

    logic               stepLast;
    logic               pwm;
    motorPwmPkg::phaseT phase;

    motorCfgIf cfgIf ();

    motorRegs uRegs (
        .clk      (clk),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .cmdAddr  (cmdAddr),
        .cmdData  (cmdData),
        .stepLast (stepLast),
        .cfg      (cfgIf.src)
    );

    stepSequencer uSeq (
        .clk      (clk),
        .rstN     (rstN),
        .cfg      (cfgIf.seq),
        .stepLast (stepLast),
        .phase    (phase)
    );

    pwmGenerator uPwm (
        .clk      (clk),
        .rstN     (rstN),
        .cfg      (cfgIf.pwm),
        .stepLast (stepLast),
        .pwm      (pwm)
    );

    gateDriver uGate (
        .clk      (clk),
        .rstN     (rstN),
        .phase    (phase),
        .pwm      (pwm),
        .gateHi   (gateHi),
        .gateLo   (gateLo),
        .pwmOut   (pwmOut),
        .phaseOut (phaseOut)
    );

endmodule

// File: test/motorCtrlTb.sv
module motorCtrlTb;
    timeunit 1ns;
    timeprecision 1ps;

    import motorRegPkg::*;

    localparam int TEST_CYCLES = 1200 + 100 + 20 * 400 + 4200 + 4200;
    localparam int MARGIN      = 2000;

    logic        clk;
    logic        rstN;
    logic        cmdValid;
    logic        cmdReady;
    regAddrT     cmdAddr;
    logic [31:0] cmdData;
    logic        pwmOut;
    logic [2:0]  phaseOut;
    logic [2:0]  gateHi;
    logic [2:0]  gateLo;

    // six-step leg order, hi A A B B C C and lo B C C A A B
    logic [1:0] hiLeg [6] = '{0, 0, 1, 1, 2, 2};
    logic [1:0] loLeg [6] = '{1, 2, 2, 0, 0, 1};

    // reference model state
    logic        mReady;
    logic [11:0] sPwm, sMin, aPwm, aMin, mPwmCnt;
    logic [15:0] sPl, sStep, aPl, aStep, mStepCnt, mCarry, mPulse;
    logic [2:0]  mPhase, mPhaseOut, mDead, mHi, mLo;
    logic        mReloadQ, mPwmOut;
    int          acceptCnt;
    int          errors;
    int          testsFailed;
    logic [31:0] rngState;

    motorCtrlTop u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .cmdAddr  (cmdAddr),
        .cmdData  (cmdData),
        .pwmOut   (pwmOut),
        .phaseOut (phaseOut),
        .gateHi   (gateHi),
        .gateLo   (gateLo)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int nextRand(input int lo, input int hi);
        rngState = xorshift(rngState);
        return lo + int'(rngState % (hi - lo + 1));
    endfunction

    // cycle model of the drive
    always @(posedge clk or negedge rstN) begin
        logic        acc, last, reload, load, short, blank;
        logic [15:0] cand;
        if (!rstN) begin
            mReady    = 1;
            sPwm      = PWM_LEN_RST;
            sMin      = MIN_MASK_RST;
            sPl       = PL_LEN_RST;
            sStep     = STEP_LEN_RST;
            aPwm      = PWM_LEN_RST;
            aMin      = MIN_MASK_RST;
            aPl       = PL_LEN_RST;
            aStep     = STEP_LEN_RST;
            mPwmCnt   = 1;
            mStepCnt  = 0;
            mCarry    = 0;
            mPulse    = 0;
            mPhase    = 0;
            mPhaseOut = 0;
            mDead     = 0;
            mHi       = 0;
            mLo       = 0;
            mReloadQ  = 0;
            mPwmOut   = 0;
        end else begin
            acc    = cmdValid && mReady;
            last   = (mStepCnt == aStep - 16'd1);
            reload = last || (mPwmCnt == 1) || (aPl == 0);
            load   = mReloadQ && !reload;
            cand   = mCarry + aPl;
            short  = cand < {4'd0, aMin};
            blank  = (mPhase != mPhaseOut) || (mDead != 0);
            if (blank) begin
                mHi = 0;
                mLo = 0;
            end else begin
                mHi = (3'b001 << hiLeg[mPhase]) & {3{mPulse != 0}};
                mLo = 3'b001 << loLeg[mPhase];
            end
            if (mPhase != mPhaseOut) mDead = 3;
            else if (mDead != 0) mDead = mDead - 1;
            mPhaseOut = mPhase;
            mPwmOut   = (mPulse != 0);
            if (load) mPulse = short ? 16'd0 : cand;
            else if (mPulse != 0) mPulse = mPulse - 1;
            if (last) mCarry = 0;
            else if (load) mCarry = short ? cand : 16'd0;
            mReloadQ = reload;
            mPwmCnt  = reload ? aPwm : mPwmCnt - 1;
            if (last) begin
                mPhase = (mPhase == 5) ? 3'd0 : mPhase + 1;
                aPwm   = sPwm;
                aMin   = sMin;
                aPl    = sPl;
                aStep  = sStep;
            end
            mStepCnt = last ? 16'd0 : mStepCnt + 1;
            if (acc && cmdAddr == ADDR_PWM) begin
                sPwm = cmdData[31:20];
                sMin = cmdData[19:8];
            end else if (acc && cmdAddr == ADDR_MOTION) begin
                sPl   = cmdData[31:16];
                sStep = cmdData[15:0];
            end
            if (acc) acceptCnt++;
            mReady = !acc;
        end
    end

    task automatic checkVal(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Error t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
            errors++;
        end
    endtask

    // outputs are compared at the falling edge, away from any update
    always @(negedge clk) begin
        if (rstN) begin
            checkVal("cmdReady", mReady, cmdReady);
            checkVal("pwmOut", mPwmOut, pwmOut);
            checkVal("phaseOut", mPhaseOut, phaseOut);
            checkVal("gateHi", mHi, gateHi);
            checkVal("gateLo", mLo, gateLo);
            if ((gateHi & gateLo) != 0) begin
                $display("Error t=%0t a leg has both gates on, hi=%b lo=%b",
                         $time, gateHi, gateLo);
                errors++;
            end
        end
    end

    task automatic writeCmd(input regAddrT addr, input logic [31:0] data);
        int waitCycles;
        waitCycles = 0;
        cmdValid <= 1'b1;
        cmdAddr  <= addr;
        cmdData  <= data;
        @(posedge clk);
        while (!cmdReady) begin
            waitCycles++;
            if (waitCycles > 10) begin
                $display("Error t=%0t write never accepted by the DUT", $time);
                errors++;
                break;
            end
            @(posedge clk);
        end
        cmdValid <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic finishTest(input string name, input int errBefore);
        if (errors == errBefore) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errBefore);
            testsFailed++;
        end
    endtask

    initial begin
        int e0, cycles, highs, acceptBase;
        clk         = 0;
        rstN        = 0;
        cmdValid    = 0;
        cmdAddr     = ADDR_PWM;
        cmdData     = 0;
        errors      = 0;
        testsFailed = 0;
        acceptCnt   = 0;
        rngState    = 32'h8385eee6;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        // reset state and first commutation after the default step length
        e0 = errors;
        @(negedge clk);
        checkVal("gateHi", 0, gateHi);
        checkVal("gateLo", 0, gateLo);
        checkVal("pwmOut", 0, pwmOut);
        checkVal("phaseOut", 0, phaseOut);
        checkVal("cmdReady", 1, cmdReady);
        cycles = 0;
        while (phaseOut == 0 && cycles < 1100) begin
            @(negedge clk);
            cycles++;
        end
        // phase moves after a full step, phaseOut shows it one cycle later
        checkVal("cycles to first phaseOut change", STEP_LEN_RST + 1, cycles);
        finishTest("reset", e0);

        // back-to-back writes, the second one waits through the ready gap
        e0 = errors;
        @(posedge clk);
        acceptBase = acceptCnt;
        writeCmd(ADDR_PWM, {12'd60, 12'd10, 8'd0});
        writeCmd(ADDR_MOTION, {16'd20, 16'd400});
        idle(3);
        checkVal("writes accepted", 2, acceptCnt - acceptBase);
        finishTest("handshake", e0);

        // random configuration changes against the model
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            writeCmd(ADDR_PWM, {12'(nextRand(20, 200)), 12'(nextRand(0, 4095) % 64), 8'd0});
            writeCmd(ADDR_MOTION, {16'(nextRand(0, 299)), 16'(nextRand(300, 2000))});
            idle(nextRand(0, 300));
        end
        finishTest("random", e0);

        // short pulses build up in the carry before one is issued
        e0 = errors;
        writeCmd(ADDR_PWM, {12'd50, 12'd40, 8'd0});
        writeCmd(ADDR_MOTION, {16'd15, 16'd1500});
        highs = 0;
        for (int i = 0; i < 4100; i++) begin
            @(negedge clk);
            if (i > 2100 && pwmOut) highs++;
        end
        if (highs == 0) begin
            $display("Error t=%0t no pulse issued from carried length", $time);
            errors++;
        end
        finishTest("carry", e0);

        // no pulse length means no pulses at all
        e0 = errors;
        @(posedge clk);
        writeCmd(ADDR_MOTION, {16'd0, 16'd1000});
        highs = 0;
        for (int i = 0; i < 4100; i++) begin
            @(negedge clk);
            if (i > 2100 && pwmOut) highs++;
        end
        checkVal("pwmOut high cycles", 0, highs);
        finishTest("zero", e0);

        $display("tests failed: %0d, errors: %0d", testsFailed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 8);
        $display("run did not finish in time, watchdog stopped it");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: verilog.f
common/motorRegPkg.sv
common/motorPwmPkg.sv
common/motorCfgIf.sv
rtl/motorRegs.sv
rtl/stepSequencer.sv
pwm/pwmGenerator.sv
rtl/gateDriver.sv
rtl/motorCtrlTop.sv
test/motorCtrlTb.sv
